// ==== src/element_extract.sv ====
`default_nettype none

module element_extract import lane_pkg::*; (
    input  wire logic    clk_i,
    input  wire logic    rst_i,
    input  wire sew_t    vsew_i,
    input  wire el_idx_t idx_i,
    input  wire logic    sign_i,
    output vaddr_t       raddr_o,
    input  wire word_t   rdata_i,
    output word_t        operand_o
);

    logic [1:0] pos_q;
    logic       sign_q;
    logic [7:0] el_byte;
    logic [15:0] el_half;
    word_t      el_ext;

    // Word address, drops the in-word position bits
    always_comb begin
        case (vsew_i)
            SEW8:    raddr_o = vaddr_t'(idx_i >> 2);
            SEW16:   raddr_o = vaddr_t'(idx_i >> 1);
            SEW32:   raddr_o = vaddr_t'(idx_i);
            default: raddr_o = '0;
        endcase
    end

    // Position and sign line up with the registered read word
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            pos_q  <= '0;
            sign_q <= 1'b0;
        end else begin
            pos_q  <= idx_i[1:0];
            sign_q <= sign_i;
        end
    end

    always_comb begin
        el_byte = rdata_i[{pos_q, 3'b000} +: 8];
        el_half = rdata_i[{pos_q[0], 4'b0000} +: 16];
        case (vsew_i)
            SEW8:    el_ext = {{24{sign_q & el_byte[7]}}, el_byte};
            SEW16:   el_ext = {{16{sign_q & el_half[15]}}, el_half};
            SEW32:   el_ext = rdata_i;
            default: el_ext = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        operand_o <= el_ext;
    end

    a_legal_sew: assert property (@(posedge clk_i) disable iff (!rst_i)
        vsew_i inside {SEW8, SEW16, SEW32});

endmodule

`default_nettype wire

// ==== src/lane_alu.sv ====
`default_nettype none

module lane_alu import lane_pkg::*; (
    input  wire logic     clk_i,
    input  wire logic     rst_i,
    input  wire logic     valid_i,
    input  wire alu_op_t  op_i,
    input  wire opb_sel_t opb_sel_i,
    input  wire word_t    opa_i,
    input  wire word_t    vec_b_i,
    input  wire word_t    scalar_i,
    input  wire imm_t     imm_i,
    input  wire logic     imm_sign_i,
    input  wire logic     store_i,
    output word_t         result_o,
    output logic          cmp_o,
    output logic          valid_o,
    output logic          store_valid_o,
    output word_t         store_data_o
);

    word_t      imm_ext;
    word_t      opb;
    logic [4:0] shamt;
    logic       cmp;
    word_t      res;

    //////////////////////////////////////////////////
    // Operand B
    //////////////////////////////////////////////////
    always_comb begin
        imm_ext = imm_sign_i ? {{27{imm_i[4]}}, imm_i} : {27'b0, imm_i};
        case (opb_sel_i)
            VEC:     opb = vec_b_i;
            SCALAR:  opb = scalar_i;
            IMM:     opb = imm_ext;
            default: opb = '0;
        endcase
    end

    //////////////////////////////////////////////////
    // Integer ops
    //////////////////////////////////////////////////
    always_comb begin
        shamt = opb[4:0];
        cmp   = 1'b0;
        case (op_i)
            ADD:     res = opa_i + opb;
            SUB:     res = opa_i - opb;
            AND:     res = opa_i & opb;
            OR:      res = opa_i | opb;
            XOR:     res = opa_i ^ opb;
            SLL:     res = opa_i << shamt;
            SRL:     res = opa_i >> shamt;
            SRA:     res = word_t'($signed(opa_i) >>> shamt);
            MSEQ: begin
                cmp = (opa_i == opb);
                res = {31'b0, cmp};
            end
            // Signed less-than
            MSLT: begin
                cmp = ($signed(opa_i) < $signed(opb));
                res = {31'b0, cmp};
            end
            default: res = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            valid_o       <= 1'b0;
            store_valid_o <= 1'b0;
        end else begin
            valid_o       <= valid_i;
            store_valid_o <= valid_i & store_i;
        end
    end

    always_ff @(posedge clk_i) begin
        result_o     <= res;
        cmp_o        <= cmp;
        store_data_o <= opa_i;
    end

    a_legal_opb_sel: assert property (@(posedge clk_i) disable iff (!rst_i)
        valid_i |-> opb_sel_i inside {VEC, SCALAR, IMM});

endmodule

`default_nettype wire

// ==== src/lane_ctrl_pipe.sv ====
`default_nettype none

module lane_ctrl_pipe import lane_pkg::*; (
    input  wire logic     clk_i,
    input  wire logic     rst_i,
    input  wire logic     issue_i,
    input  wire el_idx_t  dst_idx_i,
    input  wire alu_op_t  alu_op_i,
    input  wire opb_sel_t opb_sel_i,
    input  wire word_t    scalar_i,
    input  wire imm_t     imm_i,
    input  wire logic     imm_sign_i,
    input  wire wsrc_t    wsrc_i,
    input  wire word_t    load_data_i,
    input  wire logic     vm_i,
    input  wire logic     store_i,
    // ALU stage, T+2
    output logic          ex_valid_o,
    output alu_op_t       ex_op_o,
    output opb_sel_t      ex_opb_sel_o,
    output word_t         ex_scalar_o,
    output imm_t          ex_imm_o,
    output logic          ex_imm_sign_o,
    output logic          ex_store_o,
    // Write-back stage, T+3
    output logic          wb_valid_o,
    output el_idx_t       wb_dst_idx_o,
    output wsrc_t         wb_wsrc_o,
    output word_t         wb_load_data_o,
    output logic          wb_vm_o,
    output logic          wb_is_mask_o
);

    logic     s1_valid;
    alu_op_t  s1_op;
    opb_sel_t s1_opb_sel;
    word_t    s1_scalar;
    imm_t     s1_imm;
    logic     s1_imm_sign;
    logic     s1_store;
    el_idx_t  s1_dst_idx, s2_dst_idx;
    wsrc_t    s1_wsrc, s2_wsrc;
    word_t    s1_load_data, s2_load_data;
    logic     s1_vm, s2_vm;
    logic     s1_is_mask, s2_is_mask;

    //////////////////////////////////////////////////
    // Stage valids
    //////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            s1_valid   <= 1'b0;
            ex_valid_o <= 1'b0;
            wb_valid_o <= 1'b0;
        end else begin
            s1_valid   <= issue_i;
            ex_valid_o <= s1_valid;
            wb_valid_o <= ex_valid_o;
        end
    end

    //////////////////////////////////////////////////
    // Field shift
    //////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        s1_op         <= alu_op_i;
        s1_opb_sel    <= opb_sel_i;
        s1_scalar     <= scalar_i;
        s1_imm        <= imm_i;
        s1_imm_sign   <= imm_sign_i;
        s1_store      <= store_i;
        s1_dst_idx    <= dst_idx_i;
        s1_wsrc       <= wsrc_i;
        s1_load_data  <= load_data_i;
        s1_vm         <= vm_i;
        // Compares target the mask file
        s1_is_mask    <= (alu_op_i == MSEQ) || (alu_op_i == MSLT);

        ex_op_o       <= s1_op;
        ex_opb_sel_o  <= s1_opb_sel;
        ex_scalar_o   <= s1_scalar;
        ex_imm_o      <= s1_imm;
        ex_imm_sign_o <= s1_imm_sign;
        ex_store_o    <= s1_store;
        s2_dst_idx    <= s1_dst_idx;
        s2_wsrc       <= s1_wsrc;
        s2_load_data  <= s1_load_data;
        s2_vm         <= s1_vm;
        s2_is_mask    <= s1_is_mask;

        wb_dst_idx_o   <= s2_dst_idx;
        wb_wsrc_o      <= s2_wsrc;
        wb_load_data_o <= s2_load_data;
        wb_vm_o        <= s2_vm;
        wb_is_mask_o   <= s2_is_mask;
    end

endmodule

`default_nettype wire

// ==== src/lane_pkg.sv ====
`default_nettype none

package lane_pkg;

    //////////////////////////////////////////////////
    // Lane geometry
    //////////////////////////////////////////////////
    localparam int VRF_DEPTH      = 256;
    localparam int ADDR_W         = 8;
    localparam int VL_MAX         = 32;
    localparam int EL_IDX_W       = 10;
    localparam int MASK_IDX_W     = 5;
    localparam int BYTES_PER_WORD = 4;

    // Issue to result, in cycles
    localparam int ALU_LATENCY    = 3;

    //////////////////////////////////////////////////
    // Vector types
    //////////////////////////////////////////////////
    typedef logic [31:0]               word_t;
    typedef logic [ADDR_W-1:0]         vaddr_t;
    typedef logic [EL_IDX_W-1:0]       el_idx_t;
    typedef logic [MASK_IDX_W-1:0]     mask_idx_t;
    typedef logic [BYTES_PER_WORD-1:0] bwen_t;
    typedef logic [4:0]                imm_t;

    // Element width, code 3 is illegal
    typedef enum logic [1:0] {
        SEW8  = 2'd0,
        SEW16 = 2'd1,
        SEW32 = 2'd2
    } sew_t;

    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        AND  = 4'd2,
        OR   = 4'd3,
        XOR  = 4'd4,
        SLL  = 4'd5,
        SRL  = 4'd6,
        SRA  = 4'd7,
        MSEQ = 4'd8,
        MSLT = 4'd9
    } alu_op_t;

    // Operand B source, code 3 is illegal
    typedef enum logic [1:0] {
        VEC    = 2'd0,
        SCALAR = 2'd1,
        IMM    = 2'd2
    } opb_sel_t;

    typedef enum logic {
        ALU  = 1'b0,
        LOAD = 1'b1
    } wsrc_t;

endpackage

`default_nettype wire

// ==== src/lane_writeback.sv ====
`default_nettype none

module lane_writeback import lane_pkg::*; (
    input  wire sew_t    vsew_i,
    input  wire logic    valid_i,
    input  wire el_idx_t dst_idx_i,
    input  wire wsrc_t   wsrc_i,
    input  wire word_t   load_data_i,
    input  wire logic    vm_i,
    input  wire logic    is_mask_i,
    input  wire word_t   alu_result_i,
    input  wire logic    cmp_i,
    input  wire logic    mask_bit_i,
    output mask_idx_t    mask_raddr_o,
    output vaddr_t       waddr_o,
    output word_t        wdata_o,
    output bwen_t        bwen_o,
    output mask_idx_t    mask_waddr_o,
    output logic         mask_wbit_o,
    output logic         mask_we_o,
    output word_t        result_o
);

    bwen_t el_bwen;
    logic  blocked;

    assign result_o = (wsrc_i == LOAD) ? load_data_i : alu_result_i;

    // Element position in the word, value replicated over every lane
    always_comb begin
        case (vsew_i)
            SEW8: begin
                waddr_o = vaddr_t'(dst_idx_i >> 2);
                wdata_o = {4{result_o[7:0]}};
                el_bwen = bwen_t'(4'b0001 << dst_idx_i[1:0]);
            end
            SEW16: begin
                waddr_o = vaddr_t'(dst_idx_i >> 1);
                wdata_o = {2{result_o[15:0]}};
                el_bwen = bwen_t'(4'b0011 << {dst_idx_i[0], 1'b0});
            end
            SEW32: begin
                waddr_o = vaddr_t'(dst_idx_i);
                wdata_o = result_o;
                el_bwen = 4'b1111;
            end
            default: begin
                waddr_o = '0;
                wdata_o = '0;
                el_bwen = '0;
            end
        endcase
    end

    //////////////////////////////////////////////////
    // Vector mask
    //////////////////////////////////////////////////
    assign mask_raddr_o = mask_idx_t'(dst_idx_i);
    assign blocked      = vm_i & ~mask_bit_i;

    assign bwen_o       = (valid_i && !is_mask_i && !blocked) ? el_bwen : '0;
    assign mask_waddr_o = mask_idx_t'(dst_idx_i);
    assign mask_wbit_o  = cmp_i;
    assign mask_we_o    = valid_i & is_mask_i & ~blocked;

endmodule

`default_nettype wire

// ==== src/mask_regfile.sv ====
`default_nettype none

module mask_regfile import lane_pkg::*; (
    input  wire logic      clk_i,
    input  wire logic      rst_i,
    input  wire mask_idx_t raddr_i,
    output logic           rbit_o,
    input  wire mask_idx_t waddr_i,
    input  wire logic      wbit_i,
    input  wire logic      we_i
);

    logic [VL_MAX-1:0] bits;

    // Combinational read
    assign rbit_o = bits[raddr_i];

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            bits <= '0;
        end else if (we_i) begin
            bits[waddr_i] <= wbit_i;
        end
    end

endmodule

`default_nettype wire

// ==== src/vector_lane.sv ====
`default_nettype none

module vector_lane import lane_pkg::*; (
    input  wire logic     clk_i,
    input  wire logic     rst_i,
    input  wire sew_t     vsew_i,
    input  wire logic     issue_i,
    input  wire el_idx_t  src_a_idx_i,
    input  wire el_idx_t  src_b_idx_i,
    input  wire el_idx_t  dst_idx_i,
    input  wire logic     sign_i,
    input  wire alu_op_t  alu_op_i,
    input  wire opb_sel_t opb_sel_i,
    input  wire word_t    scalar_i,
    input  wire imm_t     imm_i,
    input  wire logic     imm_sign_i,
    input  wire wsrc_t    wsrc_i,
    input  wire word_t    load_data_i,
    input  wire logic     vm_i,
    input  wire logic     store_i,
    output logic          result_valid_o,
    output word_t         result_o,
    output logic          store_valid_o,
    output word_t         store_data_o
);

    vaddr_t    raddr_a, raddr_b, waddr;
    word_t     rdata_a, rdata_b, opa, opb_vec, wdata, alu_result;
    bwen_t     bwen;
    mask_idx_t mask_raddr, mask_waddr;
    logic      mask_bit, mask_wbit, mask_we, cmp;

    logic      ex_valid, ex_imm_sign, ex_store;
    alu_op_t   ex_op;
    opb_sel_t  ex_opb_sel;
    word_t     ex_scalar;
    imm_t      ex_imm;
    logic      wb_valid, wb_vm, wb_is_mask;
    el_idx_t   wb_dst_idx;
    wsrc_t     wb_wsrc;
    word_t     wb_load_data;

    //////////////////////////////////////////////////
    // Register files and operand fetch
    //////////////////////////////////////////////////
    element_extract u_extract_a (
        .clk_i, .rst_i, .vsew_i, .idx_i(src_a_idx_i), .sign_i,
        .raddr_o(raddr_a), .rdata_i(rdata_a), .operand_o(opa)
    );

    element_extract u_extract_b (
        .clk_i, .rst_i, .vsew_i, .idx_i(src_b_idx_i), .sign_i,
        .raddr_o(raddr_b), .rdata_i(rdata_b), .operand_o(opb_vec)
    );

    vector_regfile u_vrf (
        .clk_i, .rst_i,
        .raddr_a_i(raddr_a), .raddr_b_i(raddr_b),
        .rdata_a_o(rdata_a), .rdata_b_o(rdata_b),
        .waddr_i(waddr), .wdata_i(wdata), .bwen_i(bwen)
    );

    mask_regfile u_vmrf (
        .clk_i, .rst_i, .raddr_i(mask_raddr), .rbit_o(mask_bit),
        .waddr_i(mask_waddr), .wbit_i(mask_wbit), .we_i(mask_we)
    );

    //////////////////////////////////////////////////
    // Control, execute, write-back
    //////////////////////////////////////////////////
    lane_ctrl_pipe u_ctrl (
        .clk_i, .rst_i, .issue_i, .dst_idx_i, .alu_op_i, .opb_sel_i,
        .scalar_i, .imm_i, .imm_sign_i, .wsrc_i, .load_data_i, .vm_i, .store_i,
        .ex_valid_o(ex_valid), .ex_op_o(ex_op), .ex_opb_sel_o(ex_opb_sel),
        .ex_scalar_o(ex_scalar), .ex_imm_o(ex_imm), .ex_imm_sign_o(ex_imm_sign),
        .ex_store_o(ex_store),
        .wb_valid_o(wb_valid), .wb_dst_idx_o(wb_dst_idx), .wb_wsrc_o(wb_wsrc),
        .wb_load_data_o(wb_load_data), .wb_vm_o(wb_vm), .wb_is_mask_o(wb_is_mask)
    );

    lane_alu u_alu (
        .clk_i, .rst_i, .valid_i(ex_valid), .op_i(ex_op), .opb_sel_i(ex_opb_sel),
        .opa_i(opa), .vec_b_i(opb_vec), .scalar_i(ex_scalar), .imm_i(ex_imm),
        .imm_sign_i(ex_imm_sign), .store_i(ex_store),
        .result_o(alu_result), .cmp_o(cmp), .valid_o(result_valid_o),
        .store_valid_o, .store_data_o
    );

    lane_writeback u_wb (
        .vsew_i, .valid_i(wb_valid), .dst_idx_i(wb_dst_idx), .wsrc_i(wb_wsrc),
        .load_data_i(wb_load_data), .vm_i(wb_vm), .is_mask_i(wb_is_mask),
        .alu_result_i(alu_result), .cmp_i(cmp), .mask_bit_i(mask_bit),
        .mask_raddr_o(mask_raddr), .waddr_o(waddr), .wdata_o(wdata), .bwen_o(bwen),
        .mask_waddr_o(mask_waddr), .mask_wbit_o(mask_wbit), .mask_we_o(mask_we),
        .result_o
    );

endmodule

`default_nettype wire

// ==== src/vector_regfile.sv ====
`default_nettype none

module vector_regfile import lane_pkg::*; (
    input  wire logic   clk_i,
    input  wire logic   rst_i,
    input  wire vaddr_t raddr_a_i,
    input  wire vaddr_t raddr_b_i,
    output word_t       rdata_a_o,
    output word_t       rdata_b_o,
    input  wire vaddr_t waddr_i,
    input  wire word_t  wdata_i,
    input  wire bwen_t  bwen_i
);

    word_t mem [VRF_DEPTH];

    //////////////////////////////////////////////////
    // Storage with registered reads
    //////////////////////////////////////////////////
    // Reads sample the array before this edge's write lands,
    // so a same-edge read of the written word returns the old value
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            rdata_a_o <= '0;
            rdata_b_o <= '0;
            for (int i = 0; i < VRF_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else begin
            rdata_a_o <= mem[raddr_a_i];
            rdata_b_o <= mem[raddr_b_i];
            // Each byte lane commits on its own enable
            for (int b = 0; b < BYTES_PER_WORD; b++) begin
                if (bwen_i[b]) begin
                    mem[waddr_i][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== tests/tb_vector_lane.sv ====
`default_nettype none

module tb_vector_lane
    import lane_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int PERIOD_NS     = 8;
    localparam int OPS_PER_PHASE = 300;
    localparam int NUM_PHASES    = 3;
    localparam int TIMEOUT_NS    = (OPS_PER_PHASE * NUM_PHASES + 100) * PERIOD_NS * 2;

    logic     clk_i;
    logic     rst_i;
    sew_t     vsew_i;
    logic     issue_i;
    el_idx_t  src_a_idx_i;
    el_idx_t  src_b_idx_i;
    el_idx_t  dst_idx_i;
    logic     sign_i;
    alu_op_t  alu_op_i;
    opb_sel_t opb_sel_i;
    word_t    scalar_i;
    imm_t     imm_i;
    logic     imm_sign_i;
    wsrc_t    wsrc_i;
    word_t    load_data_i;
    logic     vm_i;
    logic     store_i;
    logic     result_valid_o;
    word_t    result_o;
    logic     store_valid_o;
    word_t    store_data_o;

    vector_lane dut0 (.*);

    // One write waiting to land in the model
    typedef struct packed {
        int      cyc;
        el_idx_t dst;
        word_t   val;
        logic    cmp;
        logic    is_mask;
        logic    vm;
        sew_t    sew;
    } pending_t;

    word_t             vrf_model [VRF_DEPTH];
    logic [VL_MAX-1:0] mask_model;
    pending_t          pend_q[$];
    word_t             res_exp_q[$];
    int                res_due_q[$];
    word_t             st_exp_q[$];
    int                st_due_q[$];
    sew_t              phase_sew [NUM_PHASES] = '{SEW32, SEW16, SEW8};

    logic [31:0] rng;
    int          cycle;
    int          err_result;
    int          err_store;
    int          err_other;

    always #(PERIOD_NS / 2) clk_i = ~clk_i;

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////
    function automatic logic [31:0] next_random();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic word_t read_element(el_idx_t idx, sew_t sew, logic sgn);
        int    n;
        word_t w;
        word_t el;
        n = int'(idx);
        case (sew)
            SEW8: begin
                w  = vrf_model[(n / 4) % VRF_DEPTH];
                el = (w >> (8 * (n % 4))) & 32'h0000_00ff;
                if (sgn && el[7])
                    el = el | 32'hffff_ff00;
            end
            SEW16: begin
                w  = vrf_model[(n / 2) % VRF_DEPTH];
                el = (w >> (16 * (n % 2))) & 32'h0000_ffff;
                if (sgn && el[15])
                    el = el | 32'hffff_0000;
            end
            default: el = vrf_model[n % VRF_DEPTH];
        endcase
        return el;
    endfunction

    function automatic word_t select_operand_b(opb_sel_t sel, word_t vec, word_t scalar,
                                               imm_t imm, logic imm_sgn);
        word_t ext;
        ext = 32'(imm);
        if (imm_sgn && imm[4])
            ext = ext | 32'hffff_ffe0;
        case (sel)
            VEC:     return vec;
            SCALAR:  return scalar;
            default: return ext;
        endcase
    endfunction

    function automatic word_t compute_alu(alu_op_t op, word_t a, word_t b);
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            SLL:     return a << b[4:0];
            SRL:     return a >> b[4:0];
            SRA:     return word_t'($signed(a) >>> b[4:0]);
            MSEQ:    return (a == b) ? 32'd1 : 32'd0;
            MSLT:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: return '0;
        endcase
    endfunction

    function automatic void commit_write(pending_t p);
        int        n;
        int        sh;
        int        wa;
        mask_idx_t m;
        n = int'(p.dst);
        m = mask_idx_t'(n % VL_MAX);
        // Masked off, nothing lands
        if (!p.vm || mask_model[m]) begin
            if (p.is_mask) begin
                mask_model[m] = p.cmp;
            end else if (p.sew == SEW8) begin
                wa = (n / 4) % VRF_DEPTH;
                sh = 8 * (n % 4);
                vrf_model[wa] = (vrf_model[wa] & ~(32'h0000_00ff << sh))
                              | ((p.val & 32'h0000_00ff) << sh);
            end else if (p.sew == SEW16) begin
                wa = (n / 2) % VRF_DEPTH;
                sh = 16 * (n % 2);
                vrf_model[wa] = (vrf_model[wa] & ~(32'h0000_ffff << sh))
                              | ((p.val & 32'h0000_ffff) << sh);
            end else begin
                vrf_model[n % VRF_DEPTH] = p.val;
            end
        end
    endfunction

    // A read in cycle k sees writers issued before k - ALU_LATENCY
    function automatic void apply_commits(int k);
        while (pend_q.size() > 0 && pend_q[0].cyc + ALU_LATENCY < k) begin
            commit_write(pend_q.pop_front());
        end
    endfunction

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////
    task automatic check_result(word_t got, word_t exp);
        if (got !== exp) begin
            err_result++;
            $display("ERR %0t: result_o is %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_store(word_t got, word_t exp);
        if (got !== exp) begin
            err_store++;
            $display("ERR %0t: store_data_o is %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic monitor_outputs();
        if (res_due_q.size() > 0 && res_due_q[0] == cycle) begin
            if (result_valid_o) begin
                check_result(result_o, res_exp_q[0]);
            end else begin
                err_other++;
                $display("No result_valid_o pulse in cycle %0d for an issued operation", cycle);
            end
            void'(res_due_q.pop_front());
            void'(res_exp_q.pop_front());
        end else if (result_valid_o) begin
            err_other++;
            $display("result_valid_o pulsed in cycle %0d with no result expected", cycle);
        end
        if (st_due_q.size() > 0 && st_due_q[0] == cycle) begin
            if (store_valid_o) begin
                check_store(store_data_o, st_exp_q[0]);
            end else begin
                err_other++;
                $display("No store_valid_o pulse in cycle %0d for a store", cycle);
            end
            void'(st_due_q.pop_front());
            void'(st_exp_q.pop_front());
        end else if (store_valid_o) begin
            err_other++;
            $display("store_valid_o pulsed in cycle %0d with no store expected", cycle);
        end
    endtask

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////
    task automatic next_cycle();
        @(posedge clk_i);
        #1;
        cycle++;
        monitor_outputs();
    endtask

    task automatic issue_op();
        logic [31:0] r;
        logic        is_cmp;
        word_t       a;
        word_t       bv;
        word_t       b;
        word_t       res;
        pending_t    p;
        r = next_random();
        issue_i     = 1'b1;
        src_a_idx_i = el_idx_t'(r[5:0]);
        src_b_idx_i = el_idx_t'(r[11:6]);
        dst_idx_i   = el_idx_t'(r[17:12]);
        sign_i      = r[18];
        imm_sign_i  = r[19];
        imm_i       = r[24:20];
        vm_i        = (r[26:25] == 2'b00);
        store_i     = (r[28:27] == 2'b00);
        opb_sel_i   = opb_sel_t'(r[31:29] % 3);
        r = next_random();
        alu_op_i    = alu_op_t'(r % 10);
        is_cmp      = alu_op_i inside {MSEQ, MSLT};
        // Compares always take the ALU path
        wsrc_i      = (!is_cmp && r[9:8] == 2'b00) ? LOAD : ALU;
        scalar_i    = next_random();
        load_data_i = next_random();

        apply_commits(cycle);
        a   = read_element(src_a_idx_i, vsew_i, sign_i);
        bv  = read_element(src_b_idx_i, vsew_i, sign_i);
        b   = select_operand_b(opb_sel_i, bv, scalar_i, imm_i, imm_sign_i);
        res = (wsrc_i == LOAD) ? load_data_i : compute_alu(alu_op_i, a, b);
        res_exp_q.push_back(res);
        res_due_q.push_back(cycle + ALU_LATENCY);
        if (store_i) begin
            st_exp_q.push_back(a);
            st_due_q.push_back(cycle + ALU_LATENCY);
        end
        p.cyc     = cycle;
        p.dst     = dst_idx_i;
        p.val     = res;
        p.cmp     = res[0];
        p.is_mask = is_cmp;
        p.vm      = vm_i;
        p.sew     = vsew_i;
        pend_q.push_back(p);
    endtask

    initial begin
        int ops;
        clk_i       = 1'b0;
        rst_i       = 1'b0;
        vsew_i      = SEW32;
        issue_i     = 1'b0;
        src_a_idx_i = '0;
        src_b_idx_i = '0;
        dst_idx_i   = '0;
        sign_i      = 1'b0;
        alu_op_i    = ADD;
        opb_sel_i   = VEC;
        scalar_i    = '0;
        imm_i       = '0;
        imm_sign_i  = 1'b0;
        wsrc_i      = ALU;
        load_data_i = '0;
        vm_i        = 1'b0;
        store_i     = 1'b0;
        rng         = 32'h62cd_6600;
        cycle       = 0;
        err_result  = 0;
        err_store   = 0;
        err_other   = 0;
        for (int i = 0; i < VRF_DEPTH; i++) begin
            vrf_model[i] = '0;
        end
        mask_model = '0;

        repeat (5) @(posedge clk_i);
        #1;
        if (result_valid_o || store_valid_o) begin
            err_other++;
            $display("A valid output is high during reset");
        end
        rst_i = 1'b1;
        // Quiet after reset until the first issue
        repeat (4) next_cycle();

        for (int ph = 0; ph < NUM_PHASES; ph++) begin
            next_cycle();
            vsew_i = phase_sew[ph];
            ops = 0;
            while (ops < OPS_PER_PHASE) begin
                next_cycle();
                if (next_random() % 5 != 0) begin
                    issue_op();
                    ops++;
                end else begin
                    issue_i = 1'b0;
                end
            end
            // Pipeline empties before SEW moves
            repeat (ALU_LATENCY) begin
                next_cycle();
                issue_i = 1'b0;
            end
        end

        repeat (ALU_LATENCY + 3) next_cycle();
        if (res_due_q.size() > 0) begin
            err_other += res_due_q.size();
            $display("%0d results never arrived", res_due_q.size());
        end
        if (st_due_q.size() > 0) begin
            err_other += st_due_q.size();
            $display("%0d stores never arrived", st_due_q.size());
        end

        $display("Errors: result %0d, store %0d, other %0d", err_result, err_store, err_other);
        if (err_result + err_store + err_other == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
src/lane_pkg.sv
src/vector_regfile.sv
src/mask_regfile.sv
src/element_extract.sv
src/lane_ctrl_pipe.sv
src/lane_alu.sv
src/lane_writeback.sv
src/vector_lane.sv
tests/tb_vector_lane.sv
